/* Bender.yml */
package:
  name: bt_bridge

sources:
  - files:
      - verilog/bt_bridge_pkg.sv
      - verilog/sample_intake.sv
      - verilog/sample_buffer.sv
      - verilog/uart_tx.sv
      - verilog/frame_sender.sv
      - verilog/bt_bridge_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/bt_bridge_tb.sv

/* bt_bridge.f */
verilog/bt_bridge_pkg.sv
verilog/sample_intake.sv
verilog/sample_buffer.sv
verilog/uart_tx.sv
verilog/frame_sender.sv
verilog/bt_bridge_top.sv
tests/tb_clock.sv
tests/bt_bridge_tb.sv

/* tests/bt_bridge_tb.sv */
`timescale 1ns/1ns

module bt_bridge_tb;
	import bt_bridge_pkg::*;

	localparam int CYCLES_PER_BIT = 4;
	localparam int REST_CYCLES = 6;
	localparam int BURST_OFFERS = 12;
	localparam int OVERLOAD_OFFERS = 10;
	localparam int SPACED_OFFERS = 30;
	localparam int NUM_OFFERS = BURST_OFFERS + OVERLOAD_OFFERS + SPACED_OFFERS;
	localparam int CYCLE_LIMIT =
		3 * (NUM_OFFERS * FRAME_CHARS * (10 * CYCLES_PER_BIT + REST_CYCLES)) + 200;
	// Admission to selector visibility plus selection to first start bit
	localparam int SELECT_LEAD = 4;

	logic clock;
	logic reset;
	sample_in_t sample_in;
	link_timing_t timing;
	logic txd;
	logic [NUM_STREAMS-1:0][CREDIT_WIDTH-1:0] credits;
	logic [DROP_COUNT_WIDTH-1:0] drop_count;

	// Reference model state
	logic [SAMPLE_WIDTH-1:0] data_q [NUM_STREAMS][$];
	int admit_q [NUM_STREAMS][$];
	int model_credit [NUM_STREAMS];
	int expected_drops = 0;
	int admitted = 0;
	int frames_done = 0;
	int last_stream = NUM_STREAMS - 1;
	logic in_frame = 1'b0;
	logic [STREAM_ID_WIDTH-1:0] exp_stream;
	logic [SAMPLE_WIDTH-1:0] exp_sample;

	// Line monitor state
	logic in_char = 1'b0;
	int bit_time = 0;
	int idle_count = 0;
	int char_count = 0;
	logic bit_level;
	logic [CHAR_WIDTH-1:0] char_bits;

	logic [NUM_STREAMS-1:0][CREDIT_WIDTH-1:0] prev_credits;
	sample_in_t offer_seen = '0;
	int cycle = 0;
	logic [31:0] rng;

	tb_clock u_clock (
		.clock(clock),
		.reset(reset)
	);

	bt_bridge_top u_dut (
		.clock(clock),
		.reset(reset),
		.sample_in(sample_in),
		.timing(timing),
		.txd(txd),
		.credits(credits),
		.drop_count(drop_count)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic credits_within_depth(
		input logic [NUM_STREAMS-1:0][CREDIT_WIDTH-1:0] c);
		logic ok;
		ok = 1'b1;
		for (int s = 0; s < NUM_STREAMS; s++)
			if (c[s] > FIFO_DEPTH)
				ok = 1'b0;
		return ok;
	endfunction

	function automatic int queued_samples();
		int total;
		total = 0;
		for (int s = 0; s < NUM_STREAMS; s++)
			total += data_q[s].size();
		return total;
	endfunction

	task automatic fail_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		$display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, got, expected);
		$display("TEST FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic fail_text(input string what);
		$display("Error at %0t: %s", $time, what);
		$display("TEST FAILED");
		$fatal(1, "stopped at first error");
	endtask

	// Next non-empty stream above the last one served
	task automatic start_frame();
		int pick;
		int cand;
		pick = -1;
		for (int i = 1; i <= NUM_STREAMS; i++)
		begin
			cand = (last_stream + i) % NUM_STREAMS;
			if (pick < 0 && admit_q[cand].size() > 0 && admit_q[cand][0] <= cycle - SELECT_LEAD)
				pick = cand;
		end
		if (pick < 0)
			fail_text("a frame started while no sample was waiting");
		else
		begin
			exp_stream = pick;
			exp_sample = data_q[pick].pop_front();
			void'(admit_q[pick].pop_front());
			// Credit comes back when the head is popped
			model_credit[pick]++;
			last_stream = pick;
			in_frame = 1'b1;
		end
	endtask

	task automatic finish_char();
		int idx;
		idx = char_count % FRAME_CHARS;
		char_count++;
		if (idx == 0)
			assert (char_bits === CHAR_WIDTH'(exp_stream))
			else fail_value("stream character", char_bits, exp_stream);
		else if (idx == 1)
			assert (char_bits === exp_sample[15:8])
			else fail_value("high byte character", char_bits, exp_sample[15:8]);
		else
		begin
			assert (char_bits === exp_sample[7:0])
			else fail_value("low byte character", char_bits, exp_sample[7:0]);
			in_frame = 1'b0;
			frames_done++;
		end
	endtask

	task automatic watch_line();
		int bit_num;
		int phase;
		if (!in_char && txd === 1'b0)
		begin
			if (char_count > 0)
				assert (idle_count >= REST_CYCLES)
				else fail_value("idle cycles between characters", idle_count, REST_CYCLES);
			in_char = 1'b1;
			bit_time = 0;
			if (char_count % FRAME_CHARS == 0)
				start_frame();
		end
		else if (!in_char)
			idle_count++;
		if (in_char)
		begin
			bit_num = bit_time / CYCLES_PER_BIT;
			phase = bit_time % CYCLES_PER_BIT;
			// Level must hold for the whole bit period
			if (phase == 0)
				bit_level = txd;
			else
			begin
				assert (txd === bit_level)
				else fail_value("txd", txd, bit_level);
			end
			// Data bits and stop bit sampled mid-bit
			if (phase == CYCLES_PER_BIT / 2)
			begin
				if (bit_num > CHAR_WIDTH)
				begin
					assert (txd === 1'b1)
					else fail_text("stop bit is not high");
				end
				else if (bit_num > 0)
					char_bits[bit_num - 1] = txd;
			end
			if (bit_time == 10 * CYCLES_PER_BIT - 1)
			begin
				in_char = 1'b0;
				idle_count = 0;
				finish_char();
			end
			else
				bit_time++;
		end
	endtask

	// Compare against the credits seen before this edge
	task automatic check_credits();
		for (int s = 0; s < NUM_STREAMS; s++)
			assert (prev_credits[s] == model_credit[s])
			else fail_value($sformatf("credits[%0d]", s), prev_credits[s], model_credit[s]);
	endtask

	task automatic resolve_offer();
		if (offer_seen.valid)
		begin
			if (model_credit[offer_seen.stream] > 0)
			begin
				model_credit[offer_seen.stream]--;
				data_q[offer_seen.stream].push_back(offer_seen.data);
				admit_q[offer_seen.stream].push_back(cycle);
				admitted++;
			end
			else
				expected_drops++;
		end
		assert (drop_count == expected_drops)
		else fail_value("drop_count", drop_count, expected_drops);
	endtask

	task automatic drive_offer(input logic [STREAM_ID_WIDTH-1:0] stream,
		input logic [SAMPLE_WIDTH-1:0] data);
		@(posedge clock);
		#2;
		sample_in = '{valid: 1'b1, stream: stream, data: data};
	endtask

	task automatic drive_idle(input int cycles);
		repeat (cycles)
		begin
			@(posedge clock);
			#2;
			sample_in = '0;
		end
	endtask

	task automatic wait_drain();
		@(posedge clock);
		while (queued_samples() != 0 || in_frame || in_char || idle_count < 40)
			@(posedge clock);
	endtask

	task automatic check_reset_state();
		assert (txd === 1'b1)
		else fail_value("txd", txd, 1'b1);
		for (int s = 0; s < NUM_STREAMS; s++)
			assert (credits[s] == FIFO_DEPTH)
			else fail_value($sformatf("credits[%0d]", s), credits[s], FIFO_DEPTH);
		assert (drop_count == '0)
		else fail_value("drop_count", drop_count, 0);
	endtask

	assert property (@(negedge clock) disable iff (reset) credits_within_depth(credits))
	else fail_text("a credit counter went above the FIFO depth");

	always @(posedge clock)
	begin
		cycle++;
		if (cycle >= CYCLE_LIMIT)
		begin
			$display("Error at %0t: run reached its limit of %0d cycles", $time, CYCLE_LIMIT);
			$display("TEST FAILED");
			$fatal(1, "timeout");
		end
	end

	// Model runs mid-cycle between the drive and sample points
	always @(negedge clock)
	begin
		if (!reset)
		begin
			watch_line();
			check_credits();
			resolve_offer();
		end
		prev_credits = credits;
		offer_seen = sample_in;
	end

	initial
	begin
		for (int s = 0; s < NUM_STREAMS; s++)
			model_credit[s] = FIFO_DEPTH;
		sample_in = '0;
		timing = '{cycles_per_bit: TIMER_WIDTH'(CYCLES_PER_BIT),
			rest_cycles: TIMER_WIDTH'(REST_CYCLES)};
		rng = 32'h921;
		@(negedge reset);
		@(negedge clock);
		check_reset_state();

		// Back-to-back offers to random streams
		for (int i = 0; i < BURST_OFFERS; i++)
		begin
			rng = xorshift32(rng);
			drive_offer(rng[10:8], rng[31:16]);
		end
		drive_idle(2);
		wait_drain();

		// One stream offered faster than the line drains it
		for (int i = 0; i < OVERLOAD_OFFERS; i++)
		begin
			rng = xorshift32(rng);
			drive_offer(3'd5, rng[31:16]);
		end
		drive_idle(2);
		wait_drain();
		assert (expected_drops > 0)
		else fail_text("overloading one stream dropped no samples");

		// Spaced offers with random gaps
		for (int i = 0; i < SPACED_OFFERS; i++)
		begin
			rng = xorshift32(rng);
			drive_offer(rng[10:8], rng[31:16]);
			drive_idle(int'(rng[3:0]));
		end
		drive_idle(2);
		wait_drain();

		for (int s = 0; s < NUM_STREAMS; s++)
			assert (credits[s] == FIFO_DEPTH)
			else fail_value($sformatf("credits[%0d]", s), credits[s], FIFO_DEPTH);
		assert (frames_done == admitted)
		else fail_value("frames sent", frames_done, admitted);

		$display("TEST OK");
		$finish;
	end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
	output logic clock,
	output logic reset
);

	// 20 ns period
	initial
	begin
		clock = 1'b0;
		forever
			#10 clock = ~clock;
	end

	// Reset held over three rising edges
	initial
	begin
		reset = 1'b1;
		repeat (3) @(posedge clock);
		#2 reset = 1'b0;
	end

endmodule

/* verilog/bt_bridge_pkg.sv */
package bt_bridge_pkg;

	// Stream and sample geometry
	localparam int NUM_STREAMS = 8;
	localparam int STREAM_ID_WIDTH = 3;
	localparam int SAMPLE_WIDTH = 16;
	localparam int CHAR_WIDTH = 8;

	// Per-stream FIFO depth, also the starting credit of each stream
	localparam int FIFO_DEPTH = 4;
	localparam int CREDIT_WIDTH = 3;

	// Bit period and rest period inputs
	localparam int TIMER_WIDTH = 10;

	localparam int DROP_COUNT_WIDTH = 16;

	// Stream number, high byte, low byte
	localparam int FRAME_CHARS = 3;

	// One sample offered by a sensor source
	typedef struct packed {
		logic valid;
		logic [STREAM_ID_WIDTH-1:0] stream;
		logic [SAMPLE_WIDTH-1:0] data;
	} sample_in_t;

	// Stored form of a sample, split into its two line characters
	typedef struct packed {
		logic [CHAR_WIDTH-1:0] high;
		logic [CHAR_WIDTH-1:0] low;
	} sample_split_t;

	typedef struct packed {
		logic push;
		logic [STREAM_ID_WIDTH-1:0] stream;
		sample_split_t sample;
	} buffer_write_t;

	// One bit per stream, set on the cycle its FIFO is popped
	typedef struct packed {
		logic [NUM_STREAMS-1:0] pop;
	} credit_return_t;

	// Serial line timing, both in clock cycles
	typedef struct packed {
		logic [TIMER_WIDTH-1:0] cycles_per_bit;
		logic [TIMER_WIDTH-1:0] rest_cycles;
	} link_timing_t;

endpackage

/* verilog/bt_bridge_top.sv */
`timescale 1ns/1ns

module bt_bridge_top (
	input logic clock,
	input logic reset,
	input bt_bridge_pkg::sample_in_t sample_in,
	input bt_bridge_pkg::link_timing_t timing,
	output logic txd,
	output logic [bt_bridge_pkg::NUM_STREAMS-1:0][bt_bridge_pkg::CREDIT_WIDTH-1:0] credits,
	output logic [bt_bridge_pkg::DROP_COUNT_WIDTH-1:0] drop_count
);
	import bt_bridge_pkg::*;

	buffer_write_t buffer_write;
	credit_return_t credit_return;

	// Buffer to sender
	logic [NUM_STREAMS-1:0] empty;
	sample_split_t [NUM_STREAMS-1:0] heads;
	logic pop;
	logic [STREAM_ID_WIDTH-1:0] pop_stream;

	sample_intake u_intake (
		.clock(clock),
		.reset(reset),
		.sample_in(sample_in),
		.credit_return(credit_return),
		.buffer_write(buffer_write),
		.credits(credits),
		.drop_count(drop_count)
	);

	sample_buffer u_buffer (
		.clock(clock),
		.reset(reset),
		.buffer_write(buffer_write),
		.pop(pop),
		.pop_stream(pop_stream),
		.empty(empty),
		.heads(heads),
		.credit_return(credit_return)
	);

	frame_sender u_sender (
		.clock(clock),
		.reset(reset),
		.timing(timing),
		.empty(empty),
		.heads(heads),
		.pop(pop),
		.pop_stream(pop_stream),
		.txd(txd)
	);

endmodule

/* verilog/frame_sender.sv */
`timescale 1ns/1ns

module frame_sender (
	input logic clock,
	input logic reset,
	input bt_bridge_pkg::link_timing_t timing,
	input logic [bt_bridge_pkg::NUM_STREAMS-1:0] empty,
	input bt_bridge_pkg::sample_split_t [bt_bridge_pkg::NUM_STREAMS-1:0] heads,
	output logic pop,
	output logic [bt_bridge_pkg::STREAM_ID_WIDTH-1:0] pop_stream,
	output logic txd
);
	import bt_bridge_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_LATCH,
		S_CHAR,
		S_BUSY,
		S_REST
	} state_t;

	state_t state;

	// Stream of the current frame, and the last served one while idle
	logic [STREAM_ID_WIDTH-1:0] sel_stream;
	logic [STREAM_ID_WIDTH-1:0] pick;
	logic [STREAM_ID_WIDTH-1:0] cand;
	logic found;

	logic [$clog2(FRAME_CHARS)-1:0] char_idx;
	logic [TIMER_WIDTH-1:0] rest_count;
	sample_split_t frame_word;

	logic [CHAR_WIDTH-1:0] char_data;
	logic char_start;
	logic char_done;

	// Round-robin: first non-empty stream after the last one served
	always_comb
	begin
		pick = sel_stream;
		cand = sel_stream;
		found = 1'b0;
		for (int i = 1; i <= NUM_STREAMS; i++)
		begin
			cand = sel_stream + STREAM_ID_WIDTH'(i);
			if (!found && !empty[cand])
			begin
				pick = cand;
				found = 1'b1;
			end
		end
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= S_IDLE;
			// Stream 0 goes first after reset
			sel_stream <= STREAM_ID_WIDTH'(NUM_STREAMS - 1);
			char_idx <= '0;
			rest_count <= '0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					if (~&empty)
					begin
						sel_stream <= pick;
						state <= S_LATCH;
					end
				end
				S_LATCH:
				begin
					char_idx <= '0;
					state <= S_CHAR;
				end
				S_CHAR:
				begin
					state <= S_BUSY;
				end
				S_BUSY:
				begin
					if (char_done)
					begin
						rest_count <= timing.rest_cycles;
						state <= S_REST;
					end
				end
				S_REST:
				begin
					if (rest_count <= TIMER_WIDTH'(1))
					begin
						if (char_idx == FRAME_CHARS - 1)
							state <= S_IDLE;
						else
						begin
							char_idx <= char_idx + 1'b1;
							state <= S_CHAR;
						end
					end
					else
						rest_count <= rest_count - 1'b1;
				end
				default:
				begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// Head is taken in the same cycle it is popped
	always_ff @(posedge clock)
	begin
		if (state == S_LATCH)
			frame_word <= heads[sel_stream];
	end

	assign pop = (state == S_LATCH);
	assign pop_stream = sel_stream;
	assign char_start = (state == S_CHAR);

	always_comb
	begin
		case (char_idx)
			0: char_data = CHAR_WIDTH'(sel_stream);
			1: char_data = frame_word.high;
			default: char_data = frame_word.low;
		endcase
	end

	uart_tx u_tx (
		.clock(clock),
		.reset(reset),
		.cycles_per_bit(timing.cycles_per_bit),
		.char_data(char_data),
		.char_start(char_start),
		.char_done(char_done),
		.txd(txd)
	);

endmodule

/* verilog/sample_buffer.sv */
`timescale 1ns/1ns

module sample_buffer (
	input logic clock,
	input logic reset,
	input bt_bridge_pkg::buffer_write_t buffer_write,
	input logic pop,
	input logic [bt_bridge_pkg::STREAM_ID_WIDTH-1:0] pop_stream,
	output logic [bt_bridge_pkg::NUM_STREAMS-1:0] empty,
	output bt_bridge_pkg::sample_split_t [bt_bridge_pkg::NUM_STREAMS-1:0] heads,
	output bt_bridge_pkg::credit_return_t credit_return
);
	import bt_bridge_pkg::*;

	// One circular FIFO per stream
	sample_split_t mem [NUM_STREAMS][FIFO_DEPTH];
	logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr [NUM_STREAMS];
	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr [NUM_STREAMS];
	logic [CREDIT_WIDTH-1:0] count [NUM_STREAMS];

	logic [NUM_STREAMS-1:0] push_hit;
	logic [NUM_STREAMS-1:0] pop_hit;

	always_comb
	begin
		for (int s = 0; s < NUM_STREAMS; s++)
		begin
			empty[s] = (count[s] == '0);
			heads[s] = mem[s][rd_ptr[s]];
			push_hit[s] = buffer_write.push && (buffer_write.stream == STREAM_ID_WIDTH'(s));
			// An empty stream is never popped
			pop_hit[s] = pop && (pop_stream == STREAM_ID_WIDTH'(s)) && (count[s] != '0);
		end
	end

	// Each pop frees one slot, handed back as a credit
	assign credit_return = '{pop: pop_hit};

	// No full check, the credit counters keep pushes within depth
	always_ff @(posedge clock)
	begin
		if (buffer_write.push)
			mem[buffer_write.stream][wr_ptr[buffer_write.stream]] <= buffer_write.sample;
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < NUM_STREAMS; s++)
			begin
				rd_ptr[s] <= '0;
				wr_ptr[s] <= '0;
				count[s] <= '0;
			end
		end
		else
		begin
			for (int s = 0; s < NUM_STREAMS; s++)
			begin
				if (push_hit[s])
					wr_ptr[s] <= (wr_ptr[s] == FIFO_DEPTH - 1) ? '0 : wr_ptr[s] + 1'b1;
				if (pop_hit[s])
					rd_ptr[s] <= (rd_ptr[s] == FIFO_DEPTH - 1) ? '0 : rd_ptr[s] + 1'b1;

				// Occupancy
				case ({push_hit[s], pop_hit[s]})
					2'b10: count[s] <= count[s] + 1'b1;
					2'b01: count[s] <= count[s] - 1'b1;
					default: count[s] <= count[s];
				endcase
			end
		end
	end

endmodule

/* verilog/sample_intake.sv */
`timescale 1ns/1ns

module sample_intake (
	input logic clock,
	input logic reset,
	input bt_bridge_pkg::sample_in_t sample_in,
	input bt_bridge_pkg::credit_return_t credit_return,
	output bt_bridge_pkg::buffer_write_t buffer_write,
	output logic [bt_bridge_pkg::NUM_STREAMS-1:0][bt_bridge_pkg::CREDIT_WIDTH-1:0] credits,
	output logic [bt_bridge_pkg::DROP_COUNT_WIDTH-1:0] drop_count
);
	import bt_bridge_pkg::*;

	logic admit;
	logic dropped;
	logic [NUM_STREAMS-1:0] take;

	logic push_q;
	logic [STREAM_ID_WIDTH-1:0] stream_q;
	sample_split_t sample_q;

	// A sample gets in only while its stream still has credit
	assign admit = sample_in.valid && (credits[sample_in.stream] != '0);
	assign dropped = sample_in.valid && (credits[sample_in.stream] == '0);

	always_comb
	begin
		for (int s = 0; s < NUM_STREAMS; s++)
		begin
			take[s] = admit && (sample_in.stream == STREAM_ID_WIDTH'(s));
		end
	end

	// Accept and return on the same stream cancel out
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < NUM_STREAMS; s++)
			begin
				credits[s] <= CREDIT_WIDTH'(FIFO_DEPTH);
			end
		end
		else
		begin
			for (int s = 0; s < NUM_STREAMS; s++)
			begin
				case ({take[s], credit_return.pop[s]})
					2'b10: credits[s] <= credits[s] - 1'b1;
					2'b01: credits[s] <= credits[s] + 1'b1;
					default: credits[s] <= credits[s];
				endcase
			end
		end
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			push_q <= 1'b0;
			drop_count <= '0;
		end
		else
		begin
			push_q <= admit;
			if (dropped)
				drop_count <= drop_count + 1'b1;
		end
	end

	// Write payload, qualified by push_q
	always_ff @(posedge clock)
	begin
		if (admit)
		begin
			stream_q <= sample_in.stream;
			sample_q <= sample_split_t'(sample_in.data);
		end
	end

	assign buffer_write = '{push: push_q, stream: stream_q, sample: sample_q};

endmodule

/* verilog/uart_tx.sv */
`timescale 1ns/1ns

module uart_tx (
	input logic clock,
	input logic reset,
	input logic [bt_bridge_pkg::TIMER_WIDTH-1:0] cycles_per_bit,
	input logic [bt_bridge_pkg::CHAR_WIDTH-1:0] char_data,
	input logic char_start,
	output logic char_done,
	output logic txd
);
	import bt_bridge_pkg::*;

	logic busy;
	logic bit_end;
	logic [TIMER_WIDTH-1:0] bit_timer;
	// 0 is the start bit, CHAR_WIDTH + 1 the stop bit
	logic [$clog2(CHAR_WIDTH + 2)-1:0] bit_index;
	// Data bits with the stop bit on top
	logic [CHAR_WIDTH:0] shift;

	assign bit_end = busy && (bit_timer == cycles_per_bit - 1'b1);

	// Last cycle of the stop bit
	assign char_done = bit_end && (bit_index == CHAR_WIDTH + 1);

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			bit_timer <= '0;
			bit_index <= '0;
			txd <= 1'b1;
		end
		else if (!busy)
		begin
			if (char_start)
			begin
				busy <= 1'b1;
				bit_timer <= '0;
				bit_index <= '0;
				txd <= 1'b0;
			end
		end
		else if (bit_end)
		begin
			bit_timer <= '0;
			if (bit_index == CHAR_WIDTH + 1)
				busy <= 1'b0;
			else
			begin
				// LSB first, stop bit falls out last
				txd <= shift[0];
				bit_index <= bit_index + 1'b1;
			end
		end
		else
			bit_timer <= bit_timer + 1'b1;
	end

	always_ff @(posedge clock)
	begin
		if (!busy && char_start)
			shift <= {1'b1, char_data};
		else if (bit_end)
			shift <= shift >> 1;
	end

endmodule
